// File: pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// register index and instruction word widths
`define PIPE_REG_W     5
`define PIPE_INSTR_W   32

// major opcodes, bits [6:0] of the instruction word
`define PIPE_OP_NOP    7'b0000000  // bubble, all-zero word
`define PIPE_OP_R      7'b0110011
`define PIPE_OP_I      7'b0010011
`define PIPE_OP_LOAD   7'b0000011
`define PIPE_OP_STORE  7'b0100011
`define PIPE_OP_B      7'b1100011
`define PIPE_OP_JAL    7'b1101111
`define PIPE_OP_JALR   7'b1100111
`define PIPE_OP_MEM    7'b0001011  // shifted immediates

`endif

// File: pipe_pkg.sv
`include "pipe_consts.svh"

package pipe_pkg;

	typedef enum logic [6:0] {
		NOP   = `PIPE_OP_NOP,
		R     = `PIPE_OP_R,
		I     = `PIPE_OP_I,
		LOAD  = `PIPE_OP_LOAD,
		STORE = `PIPE_OP_STORE,
		B     = `PIPE_OP_B,
		JAL   = `PIPE_OP_JAL,
		JALR  = `PIPE_OP_JALR,
		MEM   = `PIPE_OP_MEM
	} opcode_t;

	typedef logic [`PIPE_REG_W-1:0] r_t;
	localparam r_t X0 = '0;  // hardwired zero register

	// decoded instruction, only the fields hazard detection looks at
	typedef struct packed {
		opcode_t opcode;
		r_t      rd;
		r_t      rs1;
		r_t      rs2;
		logic    wr_rd;  // writes rd back to the register file
	} instr_t;

	typedef enum logic [1:0] {
		RS_SEL, EX_EX_FWD_SEL, MEM_EX_FWD_SEL, MEM_MEM_FWD_SEL
	} fwd_sel_t;

	typedef enum logic [1:0] {
		B_RS_SEL, B_EX_SEL, B_MEM_SEL, B_WB_SEL
	} branch_fwd_t;

	typedef enum logic [1:0] {
		RS_STORE_SEL, EX_ID_STORE_SEL, MEM_ID_STORE_SEL, WB_ID_STORE_SEL
	} store_fwd_t;

endpackage

// File: instr_decode.sv
`include "pipe_consts.svh"

module instr_decode (
	input  logic [`PIPE_INSTR_W-1:0] word,
	output pipe_pkg::instr_t         instr
);

	logic [6:0] op;
	logic       known;  // opcode is in the supported set

	assign op = word[6:0];

	always_comb begin
		case (op)
			`PIPE_OP_R, `PIPE_OP_I, `PIPE_OP_MEM, `PIPE_OP_LOAD,
			`PIPE_OP_STORE, `PIPE_OP_B, `PIPE_OP_JAL, `PIPE_OP_JALR: known = 1'b1;
			default: known = 1'b0;
		endcase
	end

	always_comb begin
		instr = '0;  // unknown words become a bubble
		if (known) begin
			instr.opcode = pipe_pkg::opcode_t'(op);
			instr.rd     = word[11:7];
			instr.rs1    = word[19:15];
			instr.rs2    = word[24:20];
		end
		if (instr.opcode == pipe_pkg::JAL) begin
			instr.rs1 = pipe_pkg::X0;  // jal has no register source
		end
		// rs2 only exists for register-register, store and branch
		if (!(instr.opcode inside {pipe_pkg::R, pipe_pkg::STORE, pipe_pkg::B})) begin
			instr.rs2 = pipe_pkg::X0;
		end
		instr.wr_rd = instr.opcode inside {pipe_pkg::R, pipe_pkg::I, pipe_pkg::MEM,
			pipe_pkg::LOAD, pipe_pkg::JAL, pipe_pkg::JALR};
	end

endmodule

// File: pipe_stage.sv
module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,     // keep current contents
	input  logic     flush,    // kill the incoming instruction
	input  logic     up_hold,  // upstream register is frozen this cycle
	input  payload_t din,
	output payload_t dout
);

	// all-zero payload is the bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dout <= '0;
		end else if (hold) begin
			dout <= dout;
		end else if (flush || up_hold) begin
			dout <= '0;  // upstream frozen, so it must not be duplicated
		end else begin
			dout <= din;
		end
	end

endmodule

// File: mem_access.sv
module mem_access (
	input  logic             clk,
	input  logic             rst_n,
	input  pipe_pkg::instr_t instr_m,
	input  logic             mem_ack,
	output logic             mem_req,
	output logic             mem_we,
	output logic             mem_access_done
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_ACK_HI,  // req high, waiting for ack
		WAIT_ACK_LO   // req dropped, waiting for ack release
	} state_t;

	state_t state;
	logic   is_mem;

	assign is_mem = (instr_m.opcode == pipe_pkg::LOAD) || (instr_m.opcode == pipe_pkg::STORE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state           <= IDLE;
			mem_access_done <= 1'b0;
		end else begin
			mem_access_done <= 1'b0;
			case (state)
				IDLE: begin
					// done pulse still up means M holds the finished access
					if (is_mem && !mem_access_done) state <= WAIT_ACK_HI;
				end
				WAIT_ACK_HI: if (mem_ack) state <= WAIT_ACK_LO;
				WAIT_ACK_LO: begin
					if (!mem_ack) begin
						state           <= IDLE;
						mem_access_done <= 1'b1;  // M is released next edge
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign mem_req = (state == WAIT_ACK_HI);
	assign mem_we  = (instr_m.opcode == pipe_pkg::STORE);

endmodule

// File: hazard_ctrl.sv
module hazard_ctrl (
	input  pipe_pkg::instr_t      instr_d,
	input  pipe_pkg::instr_t      instr_x,
	input  pipe_pkg::instr_t      instr_m,
	input  pipe_pkg::instr_t      instr_w,
	input  logic                  sdram_init_done,
	input  logic                  mem_access_done,
	input  logic                  branch_actual,  // branch in D resolves taken

	output pipe_pkg::fwd_sel_t    fwd_a,
	output pipe_pkg::fwd_sel_t    fwd_b,
	output pipe_pkg::fwd_sel_t    fwd_m2m,
	output pipe_pkg::branch_fwd_t fwd_rs1,
	output pipe_pkg::branch_fwd_t fwd_rs2,
	output pipe_pkg::store_fwd_t  fwd_store,
	output logic                  stall_front,
	output logic                  stall_back,
	output logic                  flush_front
);

	// producer ins writes register src, x0 never counts
	function automatic logic writes(input pipe_pkg::instr_t ins, input pipe_pkg::r_t src);
		return ins.wr_rd && (ins.rd != pipe_pkg::X0) && (ins.rd == src);
	endfunction

	logic x_reads_rs1, x_reads_rs2;  // alu operands actually used in X
	logic hz_exex_a, hz_exex_b;      // M result to X
	logic hz_mex_a, hz_mex_b;        // W result to X
	logic hz_m2m;                    // W load data into M store data

	assign x_reads_rs1 = instr_x.opcode inside {pipe_pkg::R, pipe_pkg::I, pipe_pkg::MEM,
		pipe_pkg::LOAD, pipe_pkg::STORE, pipe_pkg::B, pipe_pkg::JALR};
	assign x_reads_rs2 = instr_x.opcode inside {pipe_pkg::R, pipe_pkg::B};

	always_comb begin
		hz_exex_a = x_reads_rs1 && writes(instr_m, instr_x.rs1);
		hz_exex_b = x_reads_rs2 && writes(instr_m, instr_x.rs2);
		// the newer value from M wins over W
		hz_mex_a  = x_reads_rs1 && !hz_exex_a && writes(instr_w, instr_x.rs1);
		hz_mex_b  = x_reads_rs2 && !hz_exex_b && writes(instr_w, instr_x.rs2);
		hz_m2m    = (instr_m.opcode == pipe_pkg::STORE) && writes(instr_w, instr_m.rs2);
	end

	always_comb begin
		if (hz_exex_a) begin
			fwd_a = pipe_pkg::EX_EX_FWD_SEL;
		end else if (hz_mex_a) begin
			fwd_a = pipe_pkg::MEM_EX_FWD_SEL;
		end else begin
			fwd_a = pipe_pkg::RS_SEL;
		end

		if (hz_exex_b) begin
			fwd_b = pipe_pkg::EX_EX_FWD_SEL;
		end else if (hz_mex_b) begin
			fwd_b = pipe_pkg::MEM_EX_FWD_SEL;
		end else begin
			fwd_b = pipe_pkg::RS_SEL;
		end

		fwd_m2m = hz_m2m ? pipe_pkg::MEM_MEM_FWD_SEL : pipe_pkg::RS_SEL;
	end

	logic pc_change;  // branch or jump sitting in D
	logic jump;
	logic d_store;

	assign jump      = (instr_d.opcode == pipe_pkg::JAL) || (instr_d.opcode == pipe_pkg::JALR);
	assign pc_change = jump || (instr_d.opcode == pipe_pkg::B);
	assign d_store   = (instr_d.opcode == pipe_pkg::STORE);

	// compare operands in D pick the youngest producer
	always_comb begin
		fwd_rs1 = pipe_pkg::B_RS_SEL;
		fwd_rs2 = pipe_pkg::B_RS_SEL;
		if (pc_change) begin
			if (writes(instr_x, instr_d.rs1)) fwd_rs1 = pipe_pkg::B_EX_SEL;
			else if (writes(instr_m, instr_d.rs1)) fwd_rs1 = pipe_pkg::B_MEM_SEL;
			else if (writes(instr_w, instr_d.rs1)) fwd_rs1 = pipe_pkg::B_WB_SEL;

			if (writes(instr_x, instr_d.rs2)) fwd_rs2 = pipe_pkg::B_EX_SEL;
			else if (writes(instr_m, instr_d.rs2)) fwd_rs2 = pipe_pkg::B_MEM_SEL;
			else if (writes(instr_w, instr_d.rs2)) fwd_rs2 = pipe_pkg::B_WB_SEL;
		end
	end

	// store data for the store in D
	always_comb begin
		fwd_store = pipe_pkg::RS_STORE_SEL;
		if (d_store) begin
			if (writes(instr_x, instr_d.rs2)) fwd_store = pipe_pkg::EX_ID_STORE_SEL;
			else if (writes(instr_m, instr_d.rs2)) fwd_store = pipe_pkg::MEM_ID_STORE_SEL;
			else if (writes(instr_w, instr_d.rs2)) fwd_store = pipe_pkg::WB_ID_STORE_SEL;
		end
	end

	logic load_x, load_m;
	logic load_hz;  // load result not ready for the compare in D

	assign load_x = (instr_x.opcode == pipe_pkg::LOAD) &&
		(writes(instr_x, instr_d.rs1) || writes(instr_x, instr_d.rs2));
	assign load_m = (instr_m.opcode == pipe_pkg::LOAD) &&
		(writes(instr_m, instr_d.rs1) || writes(instr_m, instr_d.rs2));
	assign load_hz = pc_change && (load_x || load_m);

	assign stall_back = ((instr_m.opcode == pipe_pkg::LOAD) ||
		(instr_m.opcode == pipe_pkg::STORE)) && !mem_access_done;

	assign stall_front = stall_back || !sdram_init_done || load_hz;

	// drop the word fetched behind a redirect
	assign flush_front = jump || ((instr_d.opcode == pipe_pkg::B) && branch_actual);

endmodule

// File: pipe_ctrl_top.sv
`include "pipe_consts.svh"

module pipe_ctrl_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`PIPE_INSTR_W-1:0] instr_f,
	input  logic                     sdram_init_done,
	input  logic                     branch_actual,
	input  logic                     mem_ack,

	output pipe_pkg::fwd_sel_t       fwd_a,
	output pipe_pkg::fwd_sel_t       fwd_b,
	output pipe_pkg::fwd_sel_t       fwd_m2m,
	output pipe_pkg::branch_fwd_t    fwd_rs1,
	output pipe_pkg::branch_fwd_t    fwd_rs2,
	output pipe_pkg::store_fwd_t     fwd_store,
	output logic                     stall_front,
	output logic                     stall_back,
	output logic                     flush_front,
	output logic                     mem_req,
	output logic                     mem_we,
	output pipe_pkg::r_t             wb_rd,
	output logic                     wb_wr
);

	logic [`PIPE_INSTR_W-1:0] word_d;
	pipe_pkg::instr_t         instr_d, instr_x, instr_m, instr_w;
	logic                     mem_access_done;

	pipe_stage #(.payload_t(logic [`PIPE_INSTR_W-1:0])) u_if_id (
		.clk, .rst_n, .hold(stall_front), .flush(flush_front), .up_hold(1'b0),
		.din(instr_f), .dout(word_d));

	instr_decode u_decode (.word(word_d), .instr(instr_d));

	// front stall keeps D and sends a bubble into X so a load ahead can drain
	pipe_stage #(.payload_t(pipe_pkg::instr_t)) u_id_ex (
		.clk, .rst_n, .hold(stall_back), .flush(1'b0), .up_hold(stall_front),
		.din(instr_d), .dout(instr_x));

	pipe_stage #(.payload_t(pipe_pkg::instr_t)) u_ex_mem (
		.clk, .rst_n, .hold(stall_back), .flush(1'b0), .up_hold(stall_back),
		.din(instr_x), .dout(instr_m));

	pipe_stage #(.payload_t(pipe_pkg::instr_t)) u_mem_wb (
		.clk, .rst_n, .hold(stall_back), .flush(1'b0), .up_hold(stall_back),
		.din(instr_m), .dout(instr_w));

	mem_access u_mem (
		.clk, .rst_n, .instr_m, .mem_ack, .mem_req, .mem_we, .mem_access_done);

	hazard_ctrl u_hazard (
		.instr_d, .instr_x, .instr_m, .instr_w,
		.sdram_init_done, .mem_access_done, .branch_actual,
		.fwd_a, .fwd_b, .fwd_m2m, .fwd_rs1, .fwd_rs2, .fwd_store,
		.stall_front, .stall_back, .flush_front);

	assign wb_rd = instr_w.rd;     // register file write port
	assign wb_wr = instr_w.wr_rd;

endmodule

// File: tb_clock.sv
module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // period 20
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: pipe_ctrl_checker.sv
module pipe_ctrl_checker (
	input logic                  clk,
	input logic                  rst_n,
	input logic [31:0]           instr_f,
	input logic                  sdram_init_done,
	input logic                  branch_actual,
	input logic                  mem_ack,
	input pipe_pkg::fwd_sel_t    fwd_a,
	input pipe_pkg::fwd_sel_t    fwd_b,
	input pipe_pkg::fwd_sel_t    fwd_m2m,
	input pipe_pkg::branch_fwd_t fwd_rs1,
	input pipe_pkg::branch_fwd_t fwd_rs2,
	input pipe_pkg::store_fwd_t  fwd_store,
	input logic                  stall_front,
	input logic                  stall_back,
	input logic                  flush_front,
	input logic                  mem_req,
	input logic                  mem_we,
	input pipe_pkg::r_t          wb_rd,
	input logic                  wb_wr
);

	int errors = 0;

	logic [31:0]      m_d;  // model IF/ID word
	pipe_pkg::instr_t m_x, m_m, m_w, dd;
	int               seq_state;  // 0 idle, 1 req high, 2 wait ack low
	logic             seq_done;
	int               req_len, back_len;
	logic             prev_ack, prev_req;

	int   e_fwd_a, e_fwd_b, e_m2m, e_rs1, e_rs2, e_store;
	logic e_sb, e_sf, e_flush, load_hz, pc_chg;

	function automatic pipe_pkg::instr_t decode(input logic [31:0] w);
		pipe_pkg::instr_t r;
		pipe_pkg::opcode_t op;
		r  = '0;
		op = pipe_pkg::opcode_t'(w[6:0]);
		if (op inside {pipe_pkg::R, pipe_pkg::I, pipe_pkg::LOAD, pipe_pkg::STORE,
			pipe_pkg::B, pipe_pkg::JAL, pipe_pkg::JALR, pipe_pkg::MEM}) begin
			r.opcode = op;
			r.rd     = w[11:7];
			r.rs1    = (op == pipe_pkg::JAL) ? '0 : w[19:15];
			r.rs2    = (op inside {pipe_pkg::R, pipe_pkg::STORE, pipe_pkg::B}) ? w[24:20] : '0;
			r.wr_rd  = !(op inside {pipe_pkg::STORE, pipe_pkg::B});
		end
		return r;
	endfunction

	function automatic logic wr(input pipe_pkg::instr_t p, input pipe_pkg::r_t s);
		return p.wr_rd && p.rd != 0 && p.rd == s;
	endfunction

	// 0 none, 1 X, 2 M, 3 W, youngest first
	function automatic int youngest(input pipe_pkg::r_t s, input logic en);
		if (!en) return 0;
		if (wr(m_x, s)) return 1;
		if (wr(m_m, s)) return 2;
		if (wr(m_w, s)) return 3;
		return 0;
	endfunction

	always_comb begin
		dd      = decode(m_d);
		pc_chg  = dd.opcode inside {pipe_pkg::B, pipe_pkg::JAL, pipe_pkg::JALR};
		e_sb    = (m_m.opcode inside {pipe_pkg::LOAD, pipe_pkg::STORE}) && !seq_done;
		load_hz = pc_chg &&
			((m_x.opcode == pipe_pkg::LOAD && (wr(m_x, dd.rs1) || wr(m_x, dd.rs2))) ||
			(m_m.opcode == pipe_pkg::LOAD && (wr(m_m, dd.rs1) || wr(m_m, dd.rs2))));
		e_sf    = e_sb || !sdram_init_done || load_hz;
		e_flush = dd.opcode inside {pipe_pkg::JAL, pipe_pkg::JALR} ||
			(dd.opcode == pipe_pkg::B && branch_actual);
		e_fwd_a = wr(m_m, m_x.rs1) ? 1 : (wr(m_w, m_x.rs1) ? 2 : 0);
		e_fwd_b = 0;
		if (m_x.opcode inside {pipe_pkg::R, pipe_pkg::B}) begin  // alu b from a register
			e_fwd_b = wr(m_m, m_x.rs2) ? 1 : (wr(m_w, m_x.rs2) ? 2 : 0);
		end
		e_m2m   = (m_m.opcode == pipe_pkg::STORE && wr(m_w, m_m.rs2)) ? 3 : 0;
		e_rs1   = youngest(dd.rs1, pc_chg);
		e_rs2   = youngest(dd.rs2, pc_chg);
		e_store = youngest(dd.rs2, dd.opcode == pipe_pkg::STORE);
	end

	task automatic compare(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_d <= '0;
			m_x <= '0;
			m_m <= '0;
			m_w <= '0;
			seq_state <= 0;
			seq_done  <= 1'b0;
			req_len   <= 0;
			back_len  <= 0;
			prev_ack  <= 1'b0;
			prev_req  <= 1'b0;
		end else begin
			compare("fwd_a", e_fwd_a, int'(fwd_a));
			compare("fwd_b", e_fwd_b, int'(fwd_b));
			compare("fwd_m2m", e_m2m, int'(fwd_m2m));
			compare("fwd_rs1", e_rs1, int'(fwd_rs1));
			compare("fwd_rs2", e_rs2, int'(fwd_rs2));
			compare("fwd_store", e_store, int'(fwd_store));
			compare("stall_front", e_sf, stall_front);
			compare("stall_back", e_sb, stall_back);
			compare("flush_front", e_flush, flush_front);
			compare("mem_req", seq_state == 1, mem_req);
			compare("mem_we", m_m.opcode == pipe_pkg::STORE, mem_we);
			compare("wb_rd", m_w.rd, wb_rd);
			compare("wb_wr", m_w.wr_rd, wb_wr);
			if (mem_req && !prev_req && prev_ack) begin
				$display("New memory request at %0t before ack fell", $time);
				errors++;
			end
			req_len  <= mem_req ? req_len + 1 : 0;
			back_len <= stall_back ? back_len + 1 : 0;
			if (req_len == 12) begin
				$display("Memory request at %0t was never acknowledged", $time);
				errors++;
			end
			if (back_len == 30) begin
				$display("Memory stall at %0t never completed", $time);
				errors++;
			end
			prev_ack <= mem_ack;
			prev_req <= mem_req;
			// model pipeline update
			if (!e_sb) begin
				m_w <= m_m;
				m_m <= m_x;
				m_x <= e_sf ? '0 : dd;
			end
			if (!e_sf) m_d <= e_flush ? '0 : instr_f;
			seq_done <= 1'b0;
			case (seq_state)
				0: if (m_m.opcode inside {pipe_pkg::LOAD, pipe_pkg::STORE} && !seq_done)
					seq_state <= 1;
				1: if (mem_ack) seq_state <= 2;
				default: if (!mem_ack) begin
					seq_state <= 0;
					seq_done  <= 1'b1;
				end
			endcase
		end
	end

endmodule

// File: pipe_ctrl_tb.sv
`include "pipe_consts.svh"

module pipe_ctrl_tb;

	logic                     clk, rst_n;
	logic [`PIPE_INSTR_W-1:0] instr_f;
	logic                     sdram_init_done, branch_actual, mem_ack;
	pipe_pkg::fwd_sel_t       fwd_a, fwd_b, fwd_m2m;
	pipe_pkg::branch_fwd_t    fwd_rs1, fwd_rs2;
	pipe_pkg::store_fwd_t     fwd_store;
	logic                     stall_front, stall_back, flush_front;
	logic                     mem_req, mem_we, wb_wr;
	pipe_pkg::r_t             wb_rd;

	int cycle;
	int ack_delay;
	int resp_state;  // 0 idle, 1 counting delay, 2 ack high, 3 ack release delay
	int wait_cnt;

	tb_clock u_clock (.clk, .rst_n);

	pipe_ctrl_top DUT (.*);

	pipe_ctrl_checker chk (.*);

	// random word with registers x0..x7
	function automatic logic [31:0] random_word();
		logic [6:0] op;
		case ($urandom % 9)
			0: op = `PIPE_OP_R;
			1: op = `PIPE_OP_I;
			2: op = `PIPE_OP_LOAD;
			3: op = `PIPE_OP_STORE;
			4: op = `PIPE_OP_B;
			5: op = `PIPE_OP_JAL;
			6: op = `PIPE_OP_JALR;
			7: op = `PIPE_OP_MEM;
			default: op = `PIPE_OP_NOP;
		endcase
		return {7'($urandom), 5'($urandom % 8), 5'($urandom % 8), 3'($urandom),
			5'($urandom % 8), op};
	endfunction

	initial begin
		void'($urandom(32'h431bd904));
		instr_f         = '0;
		sdram_init_done = 1'b0;
		branch_actual   = 1'b0;
		mem_ack         = 1'b0;
		cycle           = 0;
		ack_delay       = 0;
		resp_state      = 0;
		wait_cnt        = 0;
		while (!rst_n && wait_cnt < 20) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!rst_n) begin
			$display("reset never released");
			chk.errors++;
		end
		while (cycle < 2000) begin
			@(negedge clk);
			if (!stall_front) instr_f = random_word();  // fetch holds while stalled
			sdram_init_done = (cycle >= 10);
			branch_actual   = 1'($urandom % 2);
			// four-phase memory responder
			case (resp_state)
				0: if (mem_req) begin
					ack_delay  = $urandom % 6;
					resp_state = 1;
				end
				1: if (ack_delay == 0) begin
					mem_ack    = 1'b1;
					resp_state = 2;
				end else begin
					ack_delay--;
				end
				2: if (!mem_req) begin
					ack_delay  = $urandom % 4;  // ack may linger after req falls
					resp_state = 3;
				end
				default: if (ack_delay == 0) begin
					mem_ack    = 1'b0;
					resp_state = 0;
				end else begin
					ack_delay--;
				end
			endcase
			cycle++;
		end
		$display("Error count: %0d", chk.errors);
		if (chk.errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: pipe_ctrl.f
pipe_pkg.sv
instr_decode.sv
pipe_stage.sv
mem_access.sv
hazard_ctrl.sv
pipe_ctrl_top.sv
tb_clock.sv
pipe_ctrl_checker.sv
pipe_ctrl_tb.sv
+incdir+.

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= pipe_ctrl_tb
FILELIST  ?= pipe_ctrl.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
